//--- Makefile
# Verilator build and run of the binary32 divide unit testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := fp_div_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(SIM_LOG)
	@if grep -q "^=== PASS ===$$" $(SIM_LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(SIM_LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

//--- dv/fp_div_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// start and result protocol checks, bound into fp_div_unit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fp_div_assertions #(
    parameter int TAG_WIDTH = 4
) (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        start,
    input logic                        busy,
    input logic                        result_valid,
    input logic                        result_ack,
    input logic [fp_div_pkg::FLEN-1:0] result,
    input logic [4:0]                  fflags,
    input logic [TAG_WIDTH-1:0]        result_tag
);
    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // start only while the unit is idle
    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n) start |-> !busy)
        else begin
            fail_count++;
            $error("start pulsed while busy");
        end

    // held result until the consumer acknowledges
    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ack |=>
            $stable(result) && $stable(fflags) && $stable(result_tag))
        else begin
            fail_count++;
            $error("result changed while waiting for result_ack");
        end

    no_valid_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else begin
            fail_count++;
            $error("result_valid high during reset");
        end

endmodule

//--- dv/fp_div_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench of the binary32 divide unit, checked
// against a reference model, built from project.f
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fp_div_tb;
    import fp_div_pkg::*;

    localparam int TAG_WIDTH   = 4;
    localparam int NUM_OPS     = 70;
    localparam int MAX_LATENCY = 40;
    localparam int PERIOD      = 20;
    localparam logic [4:0] FL_NV = 5'(1 << FLAG_NV);
    localparam logic [4:0] FL_DZ = 5'(1 << FLAG_DZ);
    localparam logic [4:0] FL_OF = 5'(1 << FLAG_OF);
    localparam logic [4:0] FL_UF = 5'(1 << FLAG_UF);
    localparam logic [4:0] FL_NX = 5'(1 << FLAG_NX);

    logic                 clk, rst_n, start, result_ack;
    logic [FLEN-1:0]      a, b;
    round_mode_e          rm;
    logic [TAG_WIDTH-1:0] tag, next_tag;
    logic                 busy, result_valid;
    logic [FLEN-1:0]      result;
    logic [4:0]           fflags;
    logic [TAG_WIDTH-1:0] result_tag;
    logic [31:0]          lfsr_state;
    int                   value_errors, timeouts;

    fp_div_unit #(.TAG_WIDTH(TAG_WIDTH)) i_dut (
        .clk(clk), .rst_n(rst_n), .start(start), .a(a), .b(b), .rm(rm), .tag(tag),
        .result_ack(result_ack), .busy(busy), .result_valid(result_valid),
        .result(result), .fflags(fflags), .result_tag(result_tag)
    );

    bind fp_div_unit fp_div_assertions #(.TAG_WIDTH(TAG_WIDTH)) i_assert (
        .clk(clk), .rst_n(rst_n), .start(start), .busy(busy),
        .result_valid(result_valid), .result_ack(result_ack),
        .result(result), .fflags(fflags), .result_tag(result_tag)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // every operation fits in MAX_LATENCY cycles plus reset and slack
    initial begin
        #((NUM_OPS * MAX_LATENCY + 200) * PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("=== FAIL ===");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // exponents 100 to 154 keep the quotient in range
    function automatic logic [FLEN-1:0] random_operand();
        logic                  sign;
        logic [EXPO_WIDTH-1:0] expo;
        logic [FRAC_WIDTH-1:0] frac;
        sign = 1'(take_bits(1));
        expo = EXPO_WIDTH'(100 + take_bits(6) % 55);
        frac = FRAC_WIDTH'(take_bits(FRAC_WIDTH));
        return {sign, expo, frac};
    endfunction

    // long division model with subnormals flushed
    function automatic void divide_model(input logic [FLEN-1:0] op_a, op_b,
                                         input round_mode_e mode,
                                         output logic [FLEN-1:0] res, output logic [4:0] flags);
        logic        sign, a_zero, b_zero, a_inf, b_inf, a_nan, b_nan, a_snan, b_snan;
        logic        guard, rest, up;
        logic [49:0] num, den, q, r;
        logic [24:0] mant;
        int          e;
        flags  = '0;
        sign   = op_a[31] ^ op_b[31];
        a_zero = op_a[30:23] == 8'h00;
        b_zero = op_b[30:23] == 8'h00;
        a_inf  = op_a[30:23] == 8'hff && op_a[22:0] == '0;
        b_inf  = op_b[30:23] == 8'hff && op_b[22:0] == '0;
        a_nan  = op_a[30:23] == 8'hff && op_a[22:0] != '0;
        b_nan  = op_b[30:23] == 8'hff && op_b[22:0] != '0;
        a_snan = a_nan && !op_a[22];
        b_snan = b_nan && !op_b[22];
        if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
            res = CANONICAL_NAN;
            flags[FLAG_NV] = a_snan | b_snan | (a_zero & b_zero) | (a_inf & b_inf);
        end else if (a_inf || b_zero) begin
            res = {sign, 8'hff, 23'h0};
            flags[FLAG_DZ] = b_zero & ~a_inf;
        end else if (a_zero || b_inf) begin
            res = {sign, 31'h0};
        end else begin
            num = {26'b0, 1'b1, op_a[22:0]} << 25;
            den = {26'b0, 1'b1, op_b[22:0]};
            q   = num / den;
            r   = num % den;
            e   = int'(op_a[30:23]) - int'(op_b[30:23]) + BIAS;
            if (!q[25]) begin
                q = q << 1;
                e = e - 1;
            end
            guard = q[1];
            rest  = q[0] | (r != '0);
            case (mode)
                RNE:     up = guard & (rest | q[2]);
                RDN:     up = (guard | rest) & sign;
                RUP:     up = (guard | rest) & ~sign;
                RMM:     up = guard;
                default: up = 1'b0;
            endcase
            mant = {1'b0, q[25:2]} + 25'(up);
            if (mant[24]) begin
                mant = mant >> 1;
                e    = e + 1;
            end
            if (e >= 255) begin
                if (mode == RTZ || (mode == RDN && !sign) || (mode == RUP && sign)) begin
                    res = {sign, 8'hfe, 23'h7fffff};
                end else begin
                    res = {sign, 8'hff, 23'h0};
                end
                flags = FL_OF | FL_NX;
            end else if (e <= 0) begin
                res   = {sign, 31'h0};
                flags = FL_UF | FL_NX;
            end else begin
                res = {sign, 8'(e), mant[22:0]};
                flags[FLAG_NX] = guard | rest;
            end
        end
    endfunction

    task automatic check_result(input logic [FLEN-1:0] expected, actual);
        if (actual !== expected) begin
            $display("ERR t=%0t result expected=%h actual=%h", $time, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_flags(input logic [4:0] expected, actual);
        if (actual !== expected) begin
            $display("ERR t=%0t fflags expected=%b actual=%b", $time, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_tag(input logic [TAG_WIDTH-1:0] expected, actual);
        if (actual !== expected) begin
            $display("ERR t=%0t result_tag expected=%h actual=%h", $time, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic expected, actual);
        if (actual !== expected) begin
            $display("ERR t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic issue_op(input logic [FLEN-1:0] op_a, op_b, input round_mode_e mode);
        @(negedge clk);
        a        = op_a;
        b        = op_b;
        rm       = mode;
        tag      = next_tag;
        start    = 1'b1;
        next_tag = next_tag + TAG_WIDTH'(1);
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_result(output logic ok);
        int cycles;
        cycles = 0;
        while (!result_valid && cycles < MAX_LATENCY) begin
            @(negedge clk);
            cycles++;
        end
        ok = result_valid;
        if (!ok) begin
            $display("no result_valid within %0d cycles, time %0t", MAX_LATENCY, $time);
            timeouts++;
        end
    endtask

    // one-cycle ack after which both levels must drop
    task automatic acknowledge();
        result_ack = 1'b1;
        @(negedge clk);
        result_ack = 1'b0;
        check_level("result_valid", 1'b0, result_valid);
        check_level("busy", 1'b0, busy);
    endtask

    task automatic divide_and_check(input logic [FLEN-1:0] op_a, op_b, input round_mode_e mode,
                                    input logic [FLEN-1:0] exp_res, input logic [4:0] exp_flags,
                                    output logic [FLEN-1:0] got);
        logic ok;
        issue_op(op_a, op_b, mode);
        wait_result(ok);
        got = result;
        if (ok) begin
            check_result(exp_res, result);
            check_flags(exp_flags, fflags);
            check_tag(tag, result_tag);
            acknowledge();
        end
    endtask

    task automatic model_check(input logic [FLEN-1:0] op_a, op_b, input round_mode_e mode,
                               output logic [FLEN-1:0] got);
        logic [FLEN-1:0] exp_res;
        logic [4:0]      exp_flags;
        divide_model(op_a, op_b, mode, exp_res, exp_flags);
        divide_and_check(op_a, op_b, mode, exp_res, exp_flags, got);
    endtask

    task automatic test_exact();
        logic [FLEN-1:0] got;
        divide_and_check(32'h40c0_0000, 32'h4040_0000, RNE, 32'h4000_0000, 5'b0, got);
        divide_and_check(32'h3f80_0000, 32'h4080_0000, RNE, 32'h3e80_0000, 5'b0, got);
        divide_and_check(32'hc110_0000, 32'h4040_0000, RNE, 32'hc040_0000, 5'b0, got);
    endtask

    task automatic test_rounding();
        logic [FLEN-1:0] exp_res, got, rtz_res, rup_res;
        logic [4:0]      exp_flags;
        round_mode_e     mode;
        rtz_res = '0;
        rup_res = '0;
        for (int m = 0; m < 5; m++) begin
            mode = round_mode_e'(3'(m));
            divide_model(32'h3f80_0000, 32'h4040_0000, mode, exp_res, exp_flags);
            divide_and_check(32'h3f80_0000, 32'h4040_0000, mode, exp_res, FL_NX, got);
            if (mode == RTZ) rtz_res = exp_res;
            if (mode == RUP) rup_res = got;
        end
        // 1/3 is inexact so RUP lands one ulp above the RTZ value
        check_result(rtz_res + 32'd1, rup_res);
    endtask

    task automatic test_special();
        logic [FLEN-1:0] got;
        divide_and_check(32'h0000_0000, 32'h8000_0000, RNE, CANONICAL_NAN, FL_NV, got);
        divide_and_check(32'h7f80_0000, 32'hff80_0000, RNE, CANONICAL_NAN, FL_NV, got);
        divide_and_check(32'h7f80_0001, 32'h3f80_0000, RNE, CANONICAL_NAN, FL_NV, got);
        divide_and_check(32'h4000_0000, 32'h7fc0_0000, RNE, CANONICAL_NAN, 5'b0, got);
        divide_and_check(32'h40a0_0000, 32'h8000_0000, RNE, 32'hff80_0000, FL_DZ, got);
        divide_and_check(32'h8000_0000, 32'h40a0_0000, RNE, 32'h8000_0000, 5'b0, got);
        divide_and_check(32'h40a0_0000, 32'h7f80_0000, RNE, 32'h0000_0000, 5'b0, got);
    endtask

    task automatic test_range();
        logic [FLEN-1:0] got;
        divide_and_check(32'h7f7f_ffff, 32'h0080_0000, RNE, 32'h7f80_0000, FL_OF | FL_NX, got);
        divide_and_check(32'h7f7f_ffff, 32'h0080_0000, RTZ, 32'h7f7f_ffff, FL_OF | FL_NX, got);
        divide_and_check(32'h0080_0000, 32'h7f7f_ffff, RNE, 32'h0000_0000, FL_UF | FL_NX, got);
    endtask

    task automatic test_backpressure();
        logic [FLEN-1:0] exp_res, got;
        logic [4:0]      exp_flags;
        logic            ok;
        divide_model(32'h3fc0_0000, 32'h4020_0000, RUP, exp_res, exp_flags);
        issue_op(32'h3fc0_0000, 32'h4020_0000, RUP);
        wait_result(ok);
        if (ok) begin
            // everything stays put while the consumer stalls
            repeat (10) begin
                @(negedge clk);
                check_result(exp_res, result);
                check_flags(exp_flags, fflags);
                check_tag(tag, result_tag);
                check_level("busy", 1'b1, busy);
                check_level("result_valid", 1'b1, result_valid);
            end
            acknowledge();
        end
        model_check(32'hc2f6_e979, 32'h4149_0fdb, RNE, got);
    endtask

    task automatic test_random();
        logic [FLEN-1:0] op_a, op_b, got;
        for (int i = 0; i < 50; i++) begin
            op_a = random_operand();
            op_b = random_operand();
            model_check(op_a, op_b, round_mode_e'(3'(i % 5)), got);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        result_ack   = 1'b0;
        a            = '0;
        b            = '0;
        rm           = RNE;
        tag          = '0;
        next_tag     = '0;
        lfsr_state   = 32'h4574_a57c;
        value_errors = 0;
        timeouts     = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_exact();
        test_rounding();
        test_special();
        test_range();
        test_backpressure();
        test_random();
        repeat (2) @(negedge clk);
        $display("errors: %0d value, %0d timeout, %0d assertion",
                 value_errors, timeouts, i_dut.i_assert.fail_count);
        if (value_errors == 0 && timeouts == 0 && i_dut.i_assert.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- hdl/fp_div_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// division control: operand capture, special cases, divider
// launch, exponent and the result held until acknowledged
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fp_div_core #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  fp_div_pkg::round_mode_e           rm,
    input  logic [TAG_WIDTH-1:0]              tag,
    input  logic                              a_sign,
    input  logic                              b_sign,
    input  logic [fp_div_pkg::EXPO_WIDTH-1:0] a_expo,
    input  logic [fp_div_pkg::EXPO_WIDTH-1:0] b_expo,
    input  logic [fp_div_pkg::FRAC_WIDTH:0]   a_sig,
    input  logic [fp_div_pkg::FRAC_WIDTH:0]   b_sig,
    input  logic                              a_zero,
    input  logic                              a_inf,
    input  logic                              a_snan,
    input  logic                              a_qnan,
    input  logic                              b_zero,
    input  logic                              b_inf,
    input  logic                              b_snan,
    input  logic                              b_qnan,
    input  logic                              result_ack,
    output logic                              busy,
    output logic                              result_valid,
    output logic [fp_div_pkg::FLEN-1:0]       result,
    output logic [4:0]                        fflags,
    output logic [TAG_WIDTH-1:0]              result_tag
);
    import fp_div_pkg::*;

    localparam int XW = EXPO_WIDTH + 2;

    // registered operation
    logic                  a_sign_r, b_sign_r;
    logic [EXPO_WIDTH-1:0] a_expo_r, b_expo_r;
    logic [FRAC_WIDTH:0]   a_sig_r, b_sig_r;
    logic                  a_zero_r, a_inf_r, a_snan_r, a_qnan_r;
    logic                  b_zero_r, b_inf_r, b_snan_r, b_qnan_r;
    round_mode_e           rm_r;
    logic [TAG_WIDTH-1:0]  tag_r;

    logic                  accept, op_loaded, special_fire, div_start, div_done, capture;
    logic                  invalid, div_by_zero, out_nan, out_inf, out_zero, early_terminate;
    logic                  res_sign;
    logic [FLEN-1:0]       special_result;
    logic signed [XW-1:0]  expo_calc;

    // rounding stage inputs, held while the divider runs
    logic                  rnd_sign, rnd_special, rnd_invalid, rnd_dz;
    logic [FLEN-1:0]       rnd_special_result;
    logic signed [XW-1:0]  rnd_expo;
    logic [QUO_WIDTH-1:0]  quotient;
    logic                  sticky;
    logic [FLEN-1:0]       packed_result;
    logic [4:0]            round_flags;

    assign accept  = start & ~busy;
    assign capture = special_fire | div_done;

    always_ff @(posedge clk) begin
        if (accept) begin
            {a_sign_r, b_sign_r} <= {a_sign, b_sign};
            {a_expo_r, b_expo_r} <= {a_expo, b_expo};
            {a_sig_r, b_sig_r}   <= {a_sig, b_sig};
            {a_zero_r, a_inf_r, a_snan_r, a_qnan_r} <= {a_zero, a_inf, a_snan, a_qnan};
            {b_zero_r, b_inf_r, b_snan_r, b_qnan_r} <= {b_zero, b_inf, b_snan, b_qnan};
            rm_r  <= rm;
            tag_r <= tag;
        end
    end

    // special cases
    assign invalid = (a_zero_r & b_zero_r) | (a_inf_r & b_inf_r) | a_snan_r | b_snan_r;
    assign div_by_zero     = ~a_zero_r & ~a_inf_r & ~a_snan_r & ~a_qnan_r & b_zero_r;
    assign out_nan         = invalid | a_qnan_r | b_qnan_r;
    assign out_inf         = ~out_nan & (div_by_zero | a_inf_r);
    assign out_zero        = ~out_nan & (a_zero_r | b_inf_r);
    assign early_terminate = out_nan | out_inf | out_zero;
    assign res_sign        = a_sign_r ^ b_sign_r;

    always_comb begin
        if (out_nan) begin
            special_result = CANONICAL_NAN;
        end else if (out_inf) begin
            special_result = {res_sign, {EXPO_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
        end else begin
            special_result = {res_sign, {(FLEN-1){1'b0}}};
        end
    end

    // biased exponent before normalization
    assign expo_calc = {2'b00, a_expo_r} - {2'b00, b_expo_r} + XW'(BIAS);

    always_ff @(posedge clk) begin
        if (op_loaded) begin
            rnd_sign           <= res_sign;
            rnd_expo           <= expo_calc;
            rnd_special        <= early_terminate;
            rnd_special_result <= special_result;
            rnd_invalid        <= invalid;
            rnd_dz             <= div_by_zero;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            op_loaded    <= 1'b0;
            special_fire <= 1'b0;
            div_start    <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            op_loaded    <= accept;
            special_fire <= op_loaded & early_terminate;
            div_start    <= op_loaded & ~early_terminate;
            if (accept) begin
                busy <= 1'b1;
            end else if (result_valid && result_ack) begin
                busy <= 1'b0;
            end
            if (capture) begin
                result_valid <= 1'b1;
            end else if (result_ack) begin
                result_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            result     <= packed_result;
            fflags     <= round_flags;
            result_tag <= tag_r;
        end
    end

    mantissa_div_radix2 i_mant_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .div_start(div_start),
        .dividend (a_sig_r),
        .divisor  (b_sig_r),
        .quotient (quotient),
        .sticky   (sticky),
        .div_done (div_done)
    );

    fp_div_round i_round (
        .sign          (rnd_sign),
        .expo          (rnd_expo),
        .quotient      (quotient),
        .sticky        (sticky),
        .rm            (rm_r),
        .special       (rnd_special),
        .special_result(rnd_special_result),
        .invalid       (rnd_invalid),
        .div_by_zero   (rnd_dz),
        .packed_result (packed_result),
        .fflags        (round_flags)
    );

endmodule

//--- hdl/fp_div_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants and types of the binary32 divide unit
// import into every RTL file and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fp_div_pkg;

    // binary32 format
    localparam int FLEN       = 32;
    localparam int EXPO_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;
    localparam int BIAS       = 127;

    // integer bit, fraction bits, guard and round
    localparam int QUO_WIDTH = FRAC_WIDTH + 3;

    // quiet NaN returned for every NaN result
    localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7fc0_0000;

    // RISC-V rm field encoding
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } round_mode_e;

    // mantissa divider sequencing
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    // bit positions in the 5-bit fflags vector
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

endpackage

//--- hdl/fp_div_round.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// normalize, round and pack the quotient into binary32
// combinational, also passes special results through
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fp_div_round (
    input  logic                                  sign,
    input  logic signed [fp_div_pkg::EXPO_WIDTH+1:0] expo,
    input  logic [fp_div_pkg::QUO_WIDTH-1:0]      quotient,
    input  logic                                  sticky,
    input  fp_div_pkg::round_mode_e               rm,
    input  logic                                  special,
    input  logic [fp_div_pkg::FLEN-1:0]           special_result,
    input  logic                                  invalid,
    input  logic                                  div_by_zero,
    output logic [fp_div_pkg::FLEN-1:0]           packed_result,
    output logic [4:0]                            fflags
);
    import fp_div_pkg::*;

    localparam int XW = EXPO_WIDTH + 2;

    logic [QUO_WIDTH-1:0]  sig_norm;
    logic signed [XW-1:0]  expo_norm, expo_rnd;
    logic [FRAC_WIDTH:0]   mant;
    logic [FRAC_WIDTH+1:0] mant_rnd;
    logic [FRAC_WIDTH-1:0] frac_rnd;
    logic                  guard, rest, inexact, round_up, carry;
    logic                  overflow, underflow, max_finite;

    // quotient lies in (0.5, 2), so one left shift at most
    always_comb begin
        if (quotient[QUO_WIDTH-1]) begin
            sig_norm  = quotient;
            expo_norm = expo;
        end else begin
            sig_norm  = {quotient[QUO_WIDTH-2:0], 1'b0};
            expo_norm = expo - XW'(1);
        end
    end

    assign mant    = sig_norm[QUO_WIDTH-1:2];
    assign guard   = sig_norm[1];
    assign rest    = sig_norm[0] | sticky;
    assign inexact = guard | rest;

    always_comb begin
        case (rm)
            RNE:     round_up = guard & (rest | mant[0]);
            RTZ:     round_up = 1'b0;
            RDN:     round_up = inexact & sign;
            RUP:     round_up = inexact & ~sign;
            RMM:     round_up = guard;
            default: round_up = 1'b0;
        endcase
    end

    // carry out of 1.11..1 renormalizes to 1.0
    assign mant_rnd = {1'b0, mant} + (FRAC_WIDTH+2)'(round_up);
    assign carry    = mant_rnd[FRAC_WIDTH+1];
    assign frac_rnd = carry ? mant_rnd[FRAC_WIDTH:1] : mant_rnd[FRAC_WIDTH-1:0];
    assign expo_rnd = expo_norm + XW'(carry);

    assign overflow  = expo_rnd >= XW'((1 << EXPO_WIDTH) - 1);
    assign underflow = expo_rnd <= XW'(0);

    // directed modes that never round away from zero
    assign max_finite = (rm == RTZ) | ((rm == RDN) & ~sign) | ((rm == RUP) & sign);

    always_comb begin
        fflags = '0;
        if (special) begin
            packed_result   = special_result;
            fflags[FLAG_NV] = invalid;
            fflags[FLAG_DZ] = div_by_zero;
        end else if (overflow) begin
            if (max_finite) begin
                packed_result = {sign, {(EXPO_WIDTH-1){1'b1}}, 1'b0, {FRAC_WIDTH{1'b1}}};
            end else begin
                packed_result = {sign, {EXPO_WIDTH{1'b1}}, {FRAC_WIDTH{1'b0}}};
            end
            fflags[FLAG_OF] = 1'b1;
            fflags[FLAG_NX] = 1'b1;
        end else if (underflow) begin
            // flushed, no subnormal output
            packed_result   = {sign, {(FLEN-1){1'b0}}};
            fflags[FLAG_UF] = 1'b1;
            fflags[FLAG_NX] = 1'b1;
        end else begin
            packed_result   = {sign, expo_rnd[EXPO_WIDTH-1:0], frac_rnd};
            fflags[FLAG_NX] = inexact;
        end
    end

endmodule

//--- hdl/fp_div_unit.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// binary32 divide unit top level, start pulse in, result
// held with result_valid until result_ack
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fp_div_unit #(
    parameter int TAG_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [fp_div_pkg::FLEN-1:0] a,
    input  logic [fp_div_pkg::FLEN-1:0] b,
    input  fp_div_pkg::round_mode_e     rm,
    input  logic [TAG_WIDTH-1:0]        tag,
    input  logic                        result_ack,
    output logic                        busy,
    output logic                        result_valid,
    output logic [fp_div_pkg::FLEN-1:0] result,
    output logic [4:0]                  fflags,
    output logic [TAG_WIDTH-1:0]        result_tag
);
    import fp_div_pkg::*;

    logic                  a_sign, b_sign;
    logic [EXPO_WIDTH-1:0] a_expo, b_expo;
    logic [FRAC_WIDTH:0]   a_sig, b_sig;
    logic                  a_zero, a_inf, a_snan, a_qnan;
    logic                  b_zero, b_inf, b_snan, b_qnan;

    fp_operand_classify i_classify (
        .a(a), .b(b),
        .a_sign(a_sign), .b_sign(b_sign),
        .a_expo(a_expo), .b_expo(b_expo),
        .a_sig(a_sig), .b_sig(b_sig),
        .a_zero(a_zero), .a_inf(a_inf), .a_snan(a_snan), .a_qnan(a_qnan),
        .b_zero(b_zero), .b_inf(b_inf), .b_snan(b_snan), .b_qnan(b_qnan)
    );

    fp_div_core #(.TAG_WIDTH(TAG_WIDTH)) i_core (
        .clk(clk), .rst_n(rst_n), .start(start), .rm(rm), .tag(tag),
        .a_sign(a_sign), .b_sign(b_sign),
        .a_expo(a_expo), .b_expo(b_expo),
        .a_sig(a_sig), .b_sig(b_sig),
        .a_zero(a_zero), .a_inf(a_inf), .a_snan(a_snan), .a_qnan(a_qnan),
        .b_zero(b_zero), .b_inf(b_inf), .b_snan(b_snan), .b_qnan(b_qnan),
        .result_ack(result_ack), .busy(busy), .result_valid(result_valid),
        .result(result), .fflags(fflags), .result_tag(result_tag)
    );

endmodule

//--- hdl/fp_operand_classify.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// splits both operands into fields and flags special values
// purely combinational, subnormals are reported as zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fp_operand_classify (
    input  logic [fp_div_pkg::FLEN-1:0]       a,
    input  logic [fp_div_pkg::FLEN-1:0]       b,
    output logic                              a_sign,
    output logic                              b_sign,
    output logic [fp_div_pkg::EXPO_WIDTH-1:0] a_expo,
    output logic [fp_div_pkg::EXPO_WIDTH-1:0] b_expo,
    output logic [fp_div_pkg::FRAC_WIDTH:0]   a_sig,
    output logic [fp_div_pkg::FRAC_WIDTH:0]   b_sig,
    output logic                              a_zero,
    output logic                              a_inf,
    output logic                              a_snan,
    output logic                              a_qnan,
    output logic                              b_zero,
    output logic                              b_inf,
    output logic                              b_snan,
    output logic                              b_qnan
);
    import fp_div_pkg::*;

    // returns {zero, inf, snan, qnan} for one operand
    function automatic logic [3:0] special_flags(input logic [FLEN-1:0] op);
        logic [EXPO_WIDTH-1:0] expo;
        logic [FRAC_WIDTH-1:0] frac;
        logic                  expo_max;
        expo     = op[FLEN-2 -: EXPO_WIDTH];
        frac     = op[FRAC_WIDTH-1:0];
        expo_max = &expo;
        return {~|expo,
                expo_max & ~|frac,
                expo_max & |frac & ~frac[FRAC_WIDTH-1],
                expo_max & frac[FRAC_WIDTH-1]};
    endfunction

    // hidden bit set for any nonzero exponent
    function automatic logic [FRAC_WIDTH:0] significand(input logic [FLEN-1:0] op);
        return {|op[FLEN-2 -: EXPO_WIDTH], op[FRAC_WIDTH-1:0]};
    endfunction

    assign a_sign = a[FLEN-1];
    assign b_sign = b[FLEN-1];
    assign a_expo = a[FLEN-2 -: EXPO_WIDTH];
    assign b_expo = b[FLEN-2 -: EXPO_WIDTH];
    assign a_sig  = significand(a);
    assign b_sig  = significand(b);

    assign {a_zero, a_inf, a_snan, a_qnan} = special_flags(a);
    assign {b_zero, b_inf, b_snan, b_qnan} = special_flags(b);

endmodule

//--- hdl/mantissa_div_radix2.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// restoring radix-2 significand divider, one quotient bit
// per cycle, pulse div_start and wait for div_done
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module mantissa_div_radix2 (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             div_start,
    input  logic [fp_div_pkg::FRAC_WIDTH:0]  dividend,
    input  logic [fp_div_pkg::FRAC_WIDTH:0]  divisor,
    output logic [fp_div_pkg::QUO_WIDTH-1:0] quotient,
    output logic                             sticky,
    output logic                             div_done
);
    import fp_div_pkg::*;

    // remainder stays below twice the divisor
    localparam int REM_WIDTH = FRAC_WIDTH + 2;
    localparam int CNT_WIDTH = $clog2(QUO_WIDTH);

    div_state_e           state;
    logic [CNT_WIDTH-1:0] iter_cnt;
    logic [REM_WIDTH-1:0] rem;
    logic [REM_WIDTH-1:0] rem_next;
    logic [REM_WIDTH:0]   trial;
    logic                 q_bit;

    // trial subtract, borrow means the divisor does not fit
    assign trial    = {1'b0, rem} - {2'b00, divisor};
    assign q_bit    = ~trial[REM_WIDTH];
    assign rem_next = q_bit ? trial[REM_WIDTH-1:0] : rem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= DIV_IDLE;
            iter_cnt <= '0;
        end else begin
            unique case (state)
                DIV_IDLE: begin
                    if (div_start) begin
                        state    <= DIV_RUN;
                        iter_cnt <= '0;
                    end
                end
                DIV_RUN: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (iter_cnt == CNT_WIDTH'(QUO_WIDTH - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && div_start) begin
            rem <= {1'b0, dividend};
        end else if (state == DIV_RUN) begin
            rem      <= {rem_next[REM_WIDTH-2:0], 1'b0};
            quotient <= {quotient[QUO_WIDTH-2:0], q_bit};
        end
    end

    // quotient and remainder hold until the next launch
    assign sticky   = |rem;
    assign div_done = (state == DIV_DONE);

endmodule

//--- project.f
hdl/fp_div_pkg.sv
hdl/fp_operand_classify.sv
hdl/mantissa_div_radix2.sv
hdl/fp_div_round.sv
hdl/fp_div_core.sv
hdl/fp_div_unit.sv
dv/fp_div_assertions.sv
dv/fp_div_tb.sv
